/* source/frontend_pkg.sv */
package frontend_pkg;

    // address width of the core
    localparam int XLEN = 32;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] INIT_PC = 32'h8000_0000;

    // byte offset of the branch inside a fetch block
    localparam int OFFSET_W = 8;

    // one branch per block, conditional or unconditional
    typedef enum logic {
        BR_COND = 1'b0,
        BR_JUMP = 1'b1
    } branch_type_e;

    // payload of one ftb slot, the tag lives in the ftb itself
    typedef struct packed {
        logic                valid;
        branch_type_e        branch_type;
        logic [OFFSET_W-1:0] offset;
        logic [XLEN-1:0]     target;
        // 2-bit saturating state, 2 and 3 mean taken
        logic [1:0]          counter;
    } ftb_entry_t;

    // jumps always redirect, conditionals follow the counter msb
    function automatic logic pred_taken(input ftb_entry_t entry);
        logic taken;
        taken = (entry.branch_type == BR_JUMP) || (entry.counter >= 2'd2);
        return taken;
    endfunction

    // first byte after the branch, the branch itself is a 4-byte instruction
    function automatic logic [XLEN-1:0] calc_fallthru(
        input logic [XLEN-1:0] start,
        input ftb_entry_t      entry
    );
        logic [XLEN-1:0] offs;
        offs = {{(XLEN-OFFSET_W){1'b0}}, entry.offset};
        return start + offs + XLEN'(4);
    endfunction

    // next block start predicted from a hitting entry
    function automatic logic [XLEN-1:0] calc_npc(
        input logic [XLEN-1:0] start,
        input ftb_entry_t      entry
    );
        logic [XLEN-1:0] npc;
        if (pred_taken(entry)) begin
            npc = entry.target;
        end else begin
            npc = calc_fallthru(start, entry);
        end
        return npc;
    endfunction

endpackage

/* source/ftb.sv */
module ftb #(
    parameter int FETCH_BYTES = 16,
    parameter int FTB_ENTRIES = 64
) (
    input  logic                         clk,
    input  logic                         rst,

    // lookup from the predictor
    input  logic                         i_lookup_req,
    input  logic [frontend_pkg::XLEN-1:0] i_lookup_pc,
    output logic                         o_lookup_gnt,
    output logic                         o_lookup_hit,
    output frontend_pkg::ftb_entry_t     o_lookup_entry,

    // training write from the backend
    input  logic                         i_update_vld,
    input  logic [frontend_pkg::XLEN-1:0] i_update_pc,
    input  frontend_pkg::ftb_entry_t     i_update_entry,
    output logic                         o_update_done
);
    import frontend_pkg::*;

    // pc split: | tag | index | block offset |
    localparam int OFF_W = $clog2(FETCH_BYTES);
    localparam int IDX_W = $clog2(FTB_ENTRIES);
    localparam int TAG_W = XLEN - OFF_W - IDX_W;

    ftb_entry_t       entry_mem [FTB_ENTRIES];
    logic [TAG_W-1:0] tag_mem   [FTB_ENTRIES];

    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [IDX_W-1:0] update_idx;
    logic [TAG_W-1:0] update_tag;

    // valid-bit sweep after reset
    logic             clr_busy;
    logic [IDX_W-1:0] clr_idx;

    logic             lookup_vld_q;
    logic             tag_eq_q;
    ftb_entry_t       entry_q;
    logic             update_done_q;

    assign lookup_idx = i_lookup_pc[OFF_W +: IDX_W];
    assign lookup_tag = i_lookup_pc[XLEN-1 -: TAG_W];
    assign update_idx = i_update_pc[OFF_W +: IDX_W];
    assign update_tag = i_update_pc[XLEN-1 -: TAG_W];

    // single array port, the sweep and then the update own it
    assign o_lookup_gnt = !clr_busy && !i_update_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == IDX_W'(FTB_ENTRIES - 1)) begin
                clr_busy <= 1'b0;
            end
        end
    end

    // array write, an update arriving during the sweep is dropped
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            entry_mem[clr_idx] <= '0;
        end else if (i_update_vld) begin
            entry_mem[update_idx] <= i_update_entry;
            tag_mem[update_idx]   <= update_tag;
        end
    end

    // registered read, result holds until the next granted request
    always_ff @(posedge clk) begin
        if (i_lookup_req && o_lookup_gnt) begin
            entry_q  <= entry_mem[lookup_idx];
            tag_eq_q <= (tag_mem[lookup_idx] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_vld_q  <= 1'b0;
            update_done_q <= 1'b0;
        end else begin
            if (i_lookup_req && o_lookup_gnt) begin
                lookup_vld_q <= 1'b1;
            end
            update_done_q <= i_update_vld;
        end
    end

    assign o_lookup_hit   = lookup_vld_q && entry_q.valid && tag_eq_q;
    assign o_lookup_entry = entry_q;
    assign o_update_done  = update_done_q;

    // backend must never train a branch that lies outside the block
    a_update_offset: assert property (@(posedge clk) disable iff (rst)
        i_update_vld |-> (int'(i_update_entry.offset) < FETCH_BYTES));

endmodule

/* source/bpu.sv */
module bpu #(
    parameter int FETCH_BYTES = 16
) (
    input  logic                          clk,
    input  logic                          rst,

    // backend redirect
    input  logic                          i_squash_vld,
    input  logic [frontend_pkg::XLEN-1:0] i_squash_pc,

    // ftb lookup
    output logic                          o_lookup_req,
    output logic [frontend_pkg::XLEN-1:0] o_lookup_pc,
    input  logic                          i_lookup_gnt,
    input  logic                          i_lookup_hit,
    input  frontend_pkg::ftb_entry_t      i_lookup_entry,

    // predicted block towards the ftq
    input  logic                          i_ftq_rdy,
    output logic                          o_pred_vld,
    output logic [frontend_pkg::XLEN-1:0] o_pred_start,
    output logic [frontend_pkg::XLEN-1:0] o_pred_end,
    output logic                          o_pred_taken,
    output logic [frontend_pkg::XLEN-1:0] o_pred_target,
    output logic                          o_pred_hit
);
    import frontend_pkg::*;

    localparam logic [XLEN-1:0] BLOCK_BYTES = XLEN'(FETCH_BYTES);

    // s0 is the block being looked up this cycle
    logic [XLEN-1:0] base_pc;

    // s1 waits for the ftb result
    logic            s1_vld;
    logic [XLEN-1:0] s1_pc;

    // s2 carries the full prediction
    logic            s2_vld;
    logic [XLEN-1:0] s2_pc;
    logic            s2_hit;
    ftb_entry_t      s2_entry;

    logic stall;
    logic pred_fire;
    logic redirect;
    logic s0_accept;

    // ftq full while s2 holds a block freezes the whole pipe
    assign stall     = s2_vld && !i_ftq_rdy;
    assign pred_fire = o_pred_vld && i_ftq_rdy;
    assign redirect  = pred_fire && s2_hit;

    // no lookup while frozen or redirecting so the ftb keeps the s1 result
    assign o_lookup_req = !stall && !i_squash_vld && !redirect;
    assign o_lookup_pc  = base_pc;
    assign s0_accept    = o_lookup_req && i_lookup_gnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            base_pc <= INIT_PC;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (i_squash_vld) begin
            // backend redirect beats everything
            base_pc <= i_squash_pc;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (redirect) begin
            // follow the ftb and kill the wrong-path block in s1
            base_pc <= calc_npc(s2_pc, s2_entry);
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (!stall) begin
            s2_vld <= s1_vld;
            // an update cycle denies the grant and leaves a bubble in s1
            s1_vld <= s0_accept;
            if (s0_accept) begin
                base_pc <= base_pc + BLOCK_BYTES;
            end
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_pc    <= base_pc;
            s2_pc    <= s1_pc;
            s2_hit   <= i_lookup_hit;
            s2_entry <= i_lookup_entry;
        end
    end

    // a block squashed in the same cycle is never offered
    assign o_pred_vld    = s2_vld && !i_squash_vld;
    assign o_pred_start  = s2_pc;
    assign o_pred_target = s2_entry.target;
    assign o_pred_hit    = s2_hit;
    assign o_pred_taken  = s2_hit && pred_taken(s2_entry);

    // hit blocks stop right after the branch while misses cover the whole block
    always_comb begin
        if (s2_hit) begin
            o_pred_end = calc_fallthru(s2_pc, s2_entry) - XLEN'(1);
        end else begin
            o_pred_end = s2_pc + BLOCK_BYTES - XLEN'(1);
        end
    end

    // neither the squashed s2 block nor the one behind it in s1 is ever offered
    a_squash_no_enq: assert property (@(posedge clk) disable iff (rst)
        i_squash_vld |=> !o_pred_vld ##1 !o_pred_vld);

endmodule

/* source/ftq.sv */
module ftq #(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_squash_vld,

    // from the predictor
    input  logic                          i_enq_vld,
    output logic                          o_enq_rdy,
    input  logic [frontend_pkg::XLEN-1:0] i_enq_start,
    input  logic [frontend_pkg::XLEN-1:0] i_enq_end,
    input  logic                          i_enq_taken,
    input  logic [frontend_pkg::XLEN-1:0] i_enq_target,
    input  logic                          i_enq_hit,

    // to the backend
    input  logic                          i_deq_rdy,
    output logic                          o_deq_vld,
    output logic [frontend_pkg::XLEN-1:0] o_deq_start,
    output logic [frontend_pkg::XLEN-1:0] o_deq_end,
    output logic                          o_deq_taken,
    output logic [frontend_pkg::XLEN-1:0] o_deq_target,
    output logic                          o_deq_hit
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(FTQ_DEPTH);
    // row holds start, end, target, taken and hit
    localparam int ROW_W = 3 * XLEN + 2;

    logic [ROW_W-1:0] mem [FTQ_DEPTH];

    // extra msb is the wrap bit
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    // blocks currently held
    logic [PTR_W:0] count;

    logic empty;
    logic full;
    logic do_enq;
    logic do_deq;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]) && (wr_ptr[PTR_W] != rd_ptr[PTR_W]);
    assign count = wr_ptr - rd_ptr;

    assign o_enq_rdy = !full;
    assign o_deq_vld = !empty;
    assign do_enq    = i_enq_vld && o_enq_rdy;
    assign do_deq    = o_deq_vld && i_deq_rdy;

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr[PTR_W-1:0]] <= {i_enq_start, i_enq_end, i_enq_target, i_enq_taken, i_enq_hit};
        end
    end

    // squash drops every queued block on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_squash_vld) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign {o_deq_start, o_deq_end, o_deq_target, o_deq_taken, o_deq_hit} = mem[rd_ptr[PTR_W-1:0]];

    // a full queue either stays full or drains by one block
    a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
        (full && !i_squash_vld) |=>
            ((int'(count) == FTQ_DEPTH) || (int'(count) == FTQ_DEPTH - 1)));

    // an empty queue either stays empty or takes one block
    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst)
        (empty && !i_squash_vld) |=> (int'(count) <= 1));

endmodule

/* source/frontend_top.sv */
module frontend_top #(
    parameter int FETCH_BYTES = 16,
    parameter int FTB_ENTRIES = 64,
    parameter int FTQ_DEPTH   = 8
) (
    input  logic                          clk,
    input  logic                          rst,

    // backend redirect
    input  logic                          i_squash_vld,
    input  logic [frontend_pkg::XLEN-1:0] i_squash_pc,

    // backend training write
    input  logic                          i_update_vld,
    input  logic [frontend_pkg::XLEN-1:0] i_update_pc,
    input  frontend_pkg::ftb_entry_t      i_update_entry,
    output logic                          o_update_done,

    // fetch blocks to the backend
    input  logic                          i_fetch_rdy,
    output logic                          o_fetch_vld,
    output logic [frontend_pkg::XLEN-1:0] o_fetch_start,
    output logic [frontend_pkg::XLEN-1:0] o_fetch_end,
    output logic                          o_fetch_taken,
    output logic [frontend_pkg::XLEN-1:0] o_fetch_target,
    output logic                          o_fetch_hit
);
    import frontend_pkg::*;

    // bpu to ftb
    logic            lookup_req;
    logic [XLEN-1:0] lookup_pc;
    logic            lookup_gnt;
    logic            lookup_hit;
    ftb_entry_t      lookup_entry;

    // bpu to ftq
    logic            pred_vld;
    logic            ftq_rdy;
    logic [XLEN-1:0] pred_start;
    logic [XLEN-1:0] pred_end;
    logic            pred_taken_w;
    logic [XLEN-1:0] pred_target;
    logic            pred_hit;

    bpu #(
        .FETCH_BYTES (FETCH_BYTES)
    ) u_bpu (
        .clk            (clk),
        .rst            (rst),
        .i_squash_vld   (i_squash_vld),
        .i_squash_pc    (i_squash_pc),
        .o_lookup_req   (lookup_req),
        .o_lookup_pc    (lookup_pc),
        .i_lookup_gnt   (lookup_gnt),
        .i_lookup_hit   (lookup_hit),
        .i_lookup_entry (lookup_entry),
        .i_ftq_rdy      (ftq_rdy),
        .o_pred_vld     (pred_vld),
        .o_pred_start   (pred_start),
        .o_pred_end     (pred_end),
        .o_pred_taken   (pred_taken_w),
        .o_pred_target  (pred_target),
        .o_pred_hit     (pred_hit)
    );

    ftb #(
        .FETCH_BYTES (FETCH_BYTES),
        .FTB_ENTRIES (FTB_ENTRIES)
    ) u_ftb (
        .clk            (clk),
        .rst            (rst),
        .i_lookup_req   (lookup_req),
        .i_lookup_pc    (lookup_pc),
        .o_lookup_gnt   (lookup_gnt),
        .o_lookup_hit   (lookup_hit),
        .o_lookup_entry (lookup_entry),
        .i_update_vld   (i_update_vld),
        .i_update_pc    (i_update_pc),
        .i_update_entry (i_update_entry),
        .o_update_done  (o_update_done)
    );

    ftq #(
        .FTQ_DEPTH (FTQ_DEPTH)
    ) u_ftq (
        .clk          (clk),
        .rst          (rst),
        .i_squash_vld (i_squash_vld),
        .i_enq_vld    (pred_vld),
        .o_enq_rdy    (ftq_rdy),
        .i_enq_start  (pred_start),
        .i_enq_end    (pred_end),
        .i_enq_taken  (pred_taken_w),
        .i_enq_target (pred_target),
        .i_enq_hit    (pred_hit),
        .i_deq_rdy    (i_fetch_rdy),
        .o_deq_vld    (o_fetch_vld),
        .o_deq_start  (o_fetch_start),
        .o_deq_end    (o_fetch_end),
        .o_deq_taken  (o_fetch_taken),
        .o_deq_target (o_fetch_target),
        .o_deq_hit    (o_fetch_hit)
    );

endmodule

/* dv/frontend_tb.sv */
module frontend_tb;
    import frontend_pkg::*;

    // model copies of the dut defaults
    localparam int FETCH_BYTES = 16;
    localparam int FTB_ENTRIES = 64;
    localparam int FTQ_DEPTH   = 8;
    // first block waits for the ftb valid sweep
    localparam int POP_TIMEOUT = 200;
    localparam int WAIT_TIMEOUT = 100;

    logic            clk;
    logic            rst;
    logic            i_squash_vld;
    logic [XLEN-1:0] i_squash_pc;
    logic            i_update_vld;
    logic [XLEN-1:0] i_update_pc;
    ftb_entry_t      i_update_entry;
    logic            o_update_done;
    logic            i_fetch_rdy;
    logic            o_fetch_vld;
    logic [XLEN-1:0] o_fetch_start;
    logic [XLEN-1:0] o_fetch_end;
    logic            o_fetch_taken;
    logic [XLEN-1:0] o_fetch_target;
    logic            o_fetch_hit;

    // reference table with one slot per index like the ftb
    ftb_entry_t      model_ent [FTB_ENTRIES];
    logic [XLEN-1:0] model_pc  [FTB_ENTRIES];
    // start of the next block the model predicts
    logic [XLEN-1:0] exp_pc;
    logic [15:0]     lfsr_state;
    int              err_cnt;
    int              check_cnt;
    int              k;

    frontend_top #(
        .FETCH_BYTES (FETCH_BYTES),
        .FTB_ENTRIES (FTB_ENTRIES),
        .FTQ_DEPTH   (FTQ_DEPTH)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .i_squash_vld   (i_squash_vld),
        .i_squash_pc    (i_squash_pc),
        .i_update_vld   (i_update_vld),
        .i_update_pc    (i_update_pc),
        .i_update_entry (i_update_entry),
        .o_update_done  (o_update_done),
        .i_fetch_rdy    (i_fetch_rdy),
        .o_fetch_vld    (o_fetch_vld),
        .o_fetch_start  (o_fetch_start),
        .o_fetch_end    (o_fetch_end),
        .o_fetch_taken  (o_fetch_taken),
        .o_fetch_target (o_fetch_target),
        .o_fetch_hit    (o_fetch_hit)
    );

    always #2 clk = ~clk;

    // 16-bit galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [XLEN-1:0] rand_bits(input int n);
        logic [XLEN-1:0] v;
        int              i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // direct-mapped slot of a block address
    function automatic int model_idx(input logic [XLEN-1:0] pc);
        return int'((pc / FETCH_BYTES) % FTB_ENTRIES);
    endfunction

    // hit needs a valid slot written for the same block
    function automatic logic model_hit(input logic [XLEN-1:0] pc);
        int idx;
        idx = model_idx(pc);
        return model_ent[idx].valid && ((model_pc[idx] / FETCH_BYTES) == (pc / FETCH_BYTES));
    endfunction

    function automatic ftb_entry_t make_entry(input branch_type_e bt, input logic [XLEN-1:0] off,
                                              input logic [XLEN-1:0] tgt, input logic [1:0] ctr);
        ftb_entry_t e;
        e.valid       = 1'b1;
        e.branch_type = bt;
        e.offset      = off[OFFSET_W-1:0];
        e.target      = tgt;
        e.counter     = ctr;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // raise ready until one block transfers and sample it at the falling edge
    task automatic pop_block(output logic ok, output logic [XLEN-1:0] st,
                             output logic [XLEN-1:0] en, output logic [XLEN-1:0] tg,
                             output logic tk, output logic ht);
        int waited;
        ok = 1'b0;
        waited = 0;
        i_fetch_rdy = 1'b1;
        while (!ok && waited < POP_TIMEOUT) begin
            @(negedge clk);
            if (o_fetch_vld) begin
                ok = 1'b1;
                st = o_fetch_start;
                en = o_fetch_end;
                tg = o_fetch_target;
                tk = o_fetch_taken;
                ht = o_fetch_hit;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        i_fetch_rdy = 1'b0;
        check_cnt++;
        assert (ok) else begin
            $display("no fetch block arrived within %0d cycles", POP_TIMEOUT);
            err_cnt++;
        end
    endtask

    // pop one block and compare it with the model prediction for exp_pc
    task automatic expect_next_block(output logic [XLEN-1:0] got_start, output logic got_hit);
        logic            ok;
        logic [XLEN-1:0] st;
        logic [XLEN-1:0] en;
        logic [XLEN-1:0] tg;
        logic            tk;
        logic            ht;
        logic            exp_hit;
        ftb_entry_t      e;
        exp_hit = model_hit(exp_pc);
        e = model_ent[model_idx(exp_pc)];
        pop_block(ok, st, en, tg, tk, ht);
        got_start = st;
        got_hit = ht;
        if (ok) begin
            check_val("o_fetch_start", st, exp_pc);
            check_val("o_fetch_hit", XLEN'(ht), XLEN'(exp_hit));
            if (exp_hit) begin
                check_val("o_fetch_taken", XLEN'(tk), XLEN'(pred_taken(e)));
                check_val("o_fetch_end", en, calc_fallthru(exp_pc, e) - 1);
                check_val("o_fetch_target", tg, e.target);
                exp_pc = calc_npc(exp_pc, e);
            end else begin
                // a miss covers the whole block and leaves the target undefined
                check_val("o_fetch_taken", XLEN'(tk), '0);
                check_val("o_fetch_end", en, exp_pc + FETCH_BYTES - 1);
                exp_pc = exp_pc + FETCH_BYTES;
            end
        end
    endtask

    // one-cycle update strobe whose done pulse follows one cycle later
    task automatic write_entry(input logic [XLEN-1:0] pc, input ftb_entry_t e);
        int waited;
        i_update_vld   = 1'b1;
        i_update_pc    = pc;
        i_update_entry = e;
        @(posedge clk);
        #1;
        i_update_vld = 1'b0;
        model_ent[model_idx(pc)] = e;
        model_pc[model_idx(pc)]  = pc;
        waited = 1;
        while (!o_update_done && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_cnt++;
        assert (o_update_done && waited == 1) else begin
            $display("update done did not pulse one cycle after update valid (%0d)", waited);
            err_cnt++;
        end
        @(posedge clk);
        #1;
        check_val("o_update_done", XLEN'(o_update_done), '0);
    endtask

    task automatic squash_to(input logic [XLEN-1:0] pc);
        i_squash_vld = 1'b1;
        i_squash_pc  = pc;
        @(posedge clk);
        #1;
        i_squash_vld = 1'b0;
        exp_pc = pc;
    endtask

    task automatic sequential_fetch();
        logic [XLEN-1:0] st;
        logic            ht;
        int              n;
        for (n = 0; n < 6; n++) begin
            expect_next_block(st, ht);
        end
    endtask

    task automatic jump_redirect();
        ftb_entry_t      e;
        logic [XLEN-1:0] st;
        logic            ht;
        e = make_entry(BR_JUMP, rand_bits(2) << 2, 32'h8001_0000 | (rand_bits(8) << 4),
                       rand_bits(2));
        write_entry(32'h8000_1000, e);
        squash_to(32'h8000_1000);
        expect_next_block(st, ht);
        check_val("o_fetch_hit", XLEN'(ht), 1);
        // block after a taken jump begins at the written target
        expect_next_block(st, ht);
        check_val("o_fetch_start", st, e.target);
    endtask

    task automatic not_taken_fallthru();
        ftb_entry_t      e;
        logic [XLEN-1:0] off;
        logic [XLEN-1:0] st;
        logic            ht;
        off = rand_bits(2) << 2;
        e = make_entry(BR_COND, off, 32'h8002_0000 | (rand_bits(8) << 4), 2'd1);
        write_entry(32'h8000_2040, e);
        squash_to(32'h8000_2040);
        expect_next_block(st, ht);
        check_val("o_fetch_hit", XLEN'(ht), 1);
        // weak not-taken falls through past the 4-byte branch
        expect_next_block(st, ht);
        check_val("o_fetch_start", st, 32'h8000_2040 + off + 4);
    endtask

    task automatic backpressure_drain();
        logic [XLEN-1:0] st;
        logic            ht;
        int              waited;
        int              gap;
        int              n;
        squash_to(32'h8000_0800);
        waited = 0;
        while (i_dut.ftq_rdy && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_cnt++;
        assert (!i_dut.ftq_rdy) else begin
            $display("queue never filled while fetch ready was low");
            err_cnt++;
        end
        // drain past the queue depth with random idle gaps
        for (n = 0; n < FTQ_DEPTH + 6; n++) begin
            gap = int'(rand_bits(2));
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            expect_next_block(st, ht);
        end
    endtask

    task automatic squash_flush();
        logic [XLEN-1:0] st;
        logic            ht;
        int              waited;
        waited = 0;
        while (!o_fetch_vld && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_cnt++;
        assert (o_fetch_vld) else begin
            $display("no queued block before the squash");
            err_cnt++;
        end
        squash_to(32'h8000_3000);
        // queue is empty right after the squash edge
        check_val("o_fetch_vld", XLEN'(o_fetch_vld), '0);
        expect_next_block(st, ht);
        check_val("o_fetch_start", st, 32'h8000_3000);
        expect_next_block(st, ht);
        expect_next_block(st, ht);
    endtask

    task automatic alias_miss();
        ftb_entry_t      e;
        logic [XLEN-1:0] alias_pc;
        logic [XLEN-1:0] st;
        logic            ht;
        // same index with a tag one block-index span higher
        alias_pc = 32'h8000_5000 + FETCH_BYTES * FTB_ENTRIES;
        e = make_entry(BR_JUMP, rand_bits(2) << 2, 32'h8003_0000 | (rand_bits(8) << 4),
                       rand_bits(2));
        write_entry(32'h8000_5000, e);
        squash_to(alias_pc);
        expect_next_block(st, ht);
        check_val("o_fetch_hit", XLEN'(ht), '0);
        expect_next_block(st, ht);
        check_val("o_fetch_start", st, alias_pc + FETCH_BYTES);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        i_squash_vld   = 1'b0;
        i_squash_pc    = '0;
        i_update_vld   = 1'b0;
        i_update_pc    = '0;
        i_update_entry = '0;
        i_fetch_rdy    = 1'b0;
        err_cnt        = 0;
        check_cnt      = 0;
        lfsr_state     = 16'd74;
        exp_pc         = INIT_PC;
        for (k = 0; k < FTB_ENTRIES; k++) begin
            model_ent[k] = '0;
            model_pc[k]  = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        sequential_fetch();
        jump_redirect();
        not_taken_fallthru();
        backpressure_drain();
        squash_flush();
        alias_miss();

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* files.f */
source/frontend_pkg.sv
source/ftb.sv
source/bpu.sv
source/ftq.sv
source/frontend_top.sv
dv/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := frontend_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
